// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= oooCoreTb
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the Verilator simulation"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== flist.f ====
logic/oooPkg.sv
logic/instDecoder.sv
logic/renameTable.sv
logic/reorderBuffer.sv
logic/aluStation.sv
logic/aluUnit.sv
logic/oooCore.sv
testbench/oooCore_properties.sv
testbench/oooCoreTb.sv

// ==== logic/aluStation.sv ====
`timescale 1ns/1ns

module aluStation #(
    parameter int stationDepth = 4
) (
    input  logic clk,
    input  logic rstN,
    input  logic accept,
    input  oooPkg::decodedInst_t decoded,
    input  oooPkg::robTag_t allocTag,
    input  oooPkg::operandRead_t src1,
    input  oooPkg::operandRead_t src2,
    input  logic lookupReady1,
    input  logic [oooPkg::xlen-1:0] lookupValue1,
    input  logic lookupReady2,
    input  logic [oooPkg::xlen-1:0] lookupValue2,
    input  oooPkg::cdbResult_t cdb,
    output logic full,
    output logic issueValid,
    output oooPkg::aluOp_e issueOp,
    output logic [oooPkg::xlen-1:0] issueA,
    output logic [oooPkg::xlen-1:0] issueB,
    output oooPkg::robTag_t issueTag
);
    import oooPkg::*;

    localparam int idxWidth = (stationDepth > 1) ? $clog2(stationDepth) : 1;

    typedef struct packed {
        logic waiting;
        robTag_t tag;
        logic [xlen-1:0] value;
    } operand_t;

    // age counts the younger valid entries, so the oldest has the largest
    typedef struct packed {
        aluOp_e op;
        robTag_t dest;
        logic [idxWidth-1:0] age;
        operand_t opA;
        operand_t opB;
    } entry_t;

    logic [stationDepth-1:0] entryValid;
    entry_t entries [stationDepth];
    entry_t nextEntries [stationDepth];
    entry_t newEntry;
    logic [idxWidth-1:0] insertSlot;
    logic [idxWidth-1:0] issueSlot;

    function automatic operand_t resolve(operandRead_t src, logic robReady,
                                         logic [xlen-1:0] robValue, cdbResult_t bus);
        operand_t res;
        res = '{waiting: 1'b0, tag: src.tag, value: src.value};
        if (!src.busy) begin
            res.value = src.value;
        end else if (robReady) begin
            res.value = robValue;
        end else if (bus.valid && bus.tag == src.tag) begin
            res.value = bus.value;
        end else begin
            res.waiting = 1'b1;
        end
        return res;
    endfunction

    function automatic operand_t wake(operand_t opnd, cdbResult_t bus);
        operand_t res;
        res = opnd;
        if (opnd.waiting && bus.valid && bus.tag == opnd.tag) begin
            res.waiting = 1'b0;
            res.value = bus.value;
        end
        return res;
    endfunction

    always_comb begin
        newEntry.op = decoded.op;
        newEntry.dest = allocTag;
        newEntry.age = '0;
        newEntry.opA = resolve(src1, lookupReady1, lookupValue1, cdb);
        if (decoded.useImm) begin
            newEntry.opB = '{waiting: 1'b0, tag: '0, value: decoded.imm};
        end else begin
            newEntry.opB = resolve(src2, lookupReady2, lookupValue2, cdb);
        end
    end

    assign full = &entryValid;

    // first free slot
    always_comb begin
        insertSlot = '0;
        for (int i = stationDepth - 1; i >= 0; i--) begin
            if (!entryValid[i]) begin
                insertSlot = idxWidth'(i);
            end
        end
    end

    // oldest entry with both operands present
    always_comb begin
        logic [idxWidth-1:0] bestAge;
        issueValid = 1'b0;
        issueSlot = '0;
        bestAge = '0;
        for (int i = 0; i < stationDepth; i++) begin
            if (entryValid[i] && !entries[i].opA.waiting && !entries[i].opB.waiting) begin
                if (!issueValid || entries[i].age > bestAge) begin
                    issueValid = 1'b1;
                    issueSlot = idxWidth'(i);
                    bestAge = entries[i].age;
                end
            end
        end
    end

    assign issueOp = entries[issueSlot].op;
    assign issueA = entries[issueSlot].opA.value;
    assign issueB = entries[issueSlot].opB.value;
    assign issueTag = entries[issueSlot].dest;

    always_comb begin
        for (int i = 0; i < stationDepth; i++) begin
            nextEntries[i] = entries[i];
            nextEntries[i].opA = wake(entries[i].opA, cdb);
            nextEntries[i].opB = wake(entries[i].opB, cdb);
            if (issueValid && entries[i].age > entries[issueSlot].age) begin
                nextEntries[i].age = nextEntries[i].age - 1'b1;
            end
            if (accept) begin
                nextEntries[i].age = nextEntries[i].age + 1'b1;
            end
            if (accept && insertSlot == idxWidth'(i)) begin
                nextEntries[i] = newEntry;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            entryValid <= '0;
        end else begin
            if (issueValid) begin
                entryValid[issueSlot] <= 1'b0;
            end
            if (accept) begin
                entryValid[insertSlot] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < stationDepth; i++) begin
            entries[i] <= nextEntries[i];
        end
    end

endmodule

// ==== logic/aluUnit.sv ====
`timescale 1ns/1ns

module aluUnit (
    input  logic clk,
    input  logic rstN,
    input  logic issueValid,
    input  oooPkg::aluOp_e issueOp,
    input  logic [oooPkg::xlen-1:0] issueA,
    input  logic [oooPkg::xlen-1:0] issueB,
    input  oooPkg::robTag_t issueTag,
    output oooPkg::cdbResult_t cdb
);
    import oooPkg::*;

    logic [xlen-1:0] result;
    logic [4:0] shamt;
    logic busValid;
    robTag_t busTag;
    logic [xlen-1:0] busValue;

    assign shamt = issueB[4:0];

    always_comb begin
        case (issueOp)
            aluAdd: result = issueA + issueB;
            aluSub: result = issueA - issueB;
            aluSll: result = issueA << shamt;
            aluSlt: result = {{(xlen-1){1'b0}}, $signed(issueA) < $signed(issueB)};
            aluSltu: result = {{(xlen-1){1'b0}}, issueA < issueB};
            aluXor: result = issueA ^ issueB;
            aluSrl: result = issueA >> shamt;
            aluSra: result = $signed(issueA) >>> shamt;
            aluOr: result = issueA | issueB;
            aluAnd: result = issueA & issueB;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busValid <= 1'b0;
        end else begin
            busValid <= issueValid;
        end
    end

    always_ff @(posedge clk) begin
        busTag <= issueTag;
        busValue <= result;
    end

    assign cdb = '{valid: busValid, tag: busTag, value: busValue};

endmodule

// ==== logic/instDecoder.sv ====
`timescale 1ns/1ns

module instDecoder (
    input  logic [31:0] inst,
    output oooPkg::decodedInst_t decoded
);
    import oooPkg::*;

    opcode_e opcode;
    logic [2:0] funct3;
    logic altFunct;
    logic isImm;
    logic isShift;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    // funct7 bit 5 picks sub and sra
    assign altFunct = inst[30];
    assign isImm = (opcode == opImm);
    assign isShift = (funct3 == 3'b001) || (funct3 == 3'b101);

    always_comb begin
        decoded.op = aluAdd;
        case (funct3)
            3'b000: decoded.op = (!isImm && altFunct) ? aluSub : aluAdd;
            3'b001: decoded.op = aluSll;
            3'b010: decoded.op = aluSlt;
            3'b011: decoded.op = aluSltu;
            3'b100: decoded.op = aluXor;
            3'b101: decoded.op = altFunct ? aluSra : aluSrl;
            3'b110: decoded.op = aluOr;
            3'b111: decoded.op = aluAnd;
            default: decoded.op = aluAdd;
        endcase
    end

    always_comb begin
        decoded.rs1 = inst[19:15];
        // immediate forms carry no rs2
        decoded.rs2 = isImm ? '0 : inst[24:20];
        decoded.rd = inst[11:7];
        decoded.writesReg = (inst[11:7] != '0);
        decoded.useImm = isImm;
        if (!isImm) begin
            decoded.imm = '0;
        end else if (isShift) begin
            decoded.imm = {{(xlen-5){1'b0}}, inst[24:20]};
        end else begin
            decoded.imm = {{(xlen-12){inst[31]}}, inst[31:20]};
        end
    end

endmodule

// ==== logic/oooCore.sv ====
`timescale 1ns/1ns

module oooCore #(
    parameter int robDepth = 8,
    parameter int stationDepth = 4
) (
    input  logic clk,
    input  logic rstN,
    input  logic instValid,
    input  logic [31:0] inst,
    output logic stall,
    output oooPkg::commit_t commit
);
    import oooPkg::*;

    decodedInst_t decoded;
    operandRead_t src1;
    operandRead_t src2;
    robTag_t allocTag;
    logic accept;
    logic stationFull;
    logic lookupReady1;
    logic lookupReady2;
    logic [xlen-1:0] lookupValue1;
    logic [xlen-1:0] lookupValue2;
    logic issueValid;
    aluOp_e issueOp;
    logic [xlen-1:0] issueA;
    logic [xlen-1:0] issueB;
    robTag_t issueTag;
    // single common data bus
    cdbResult_t cdb;

    instDecoder decoder_i (
        .inst(inst),
        .decoded(decoded)
    );

    renameTable renameTable_i (
        .clk(clk),
        .rstN(rstN),
        .accept(accept),
        .decoded(decoded),
        .allocTag(allocTag),
        .commit(commit),
        .src1(src1),
        .src2(src2)
    );

    // operand tags from the rename table are looked up in the ROB
    reorderBuffer #(
        .robDepth(robDepth)
    ) reorderBuffer_i (
        .clk(clk),
        .rstN(rstN),
        .instValid(instValid),
        .stationFull(stationFull),
        .decoded(decoded),
        .cdb(cdb),
        .lookupTag1(src1.tag),
        .lookupTag2(src2.tag),
        .lookupReady1(lookupReady1),
        .lookupValue1(lookupValue1),
        .lookupReady2(lookupReady2),
        .lookupValue2(lookupValue2),
        .stall(stall),
        .accept(accept),
        .allocTag(allocTag),
        .commit(commit)
    );

    aluStation #(
        .stationDepth(stationDepth)
    ) aluStation_i (
        .clk(clk),
        .rstN(rstN),
        .accept(accept),
        .decoded(decoded),
        .allocTag(allocTag),
        .src1(src1),
        .src2(src2),
        .lookupReady1(lookupReady1),
        .lookupValue1(lookupValue1),
        .lookupReady2(lookupReady2),
        .lookupValue2(lookupValue2),
        .cdb(cdb),
        .full(stationFull),
        .issueValid(issueValid),
        .issueOp(issueOp),
        .issueA(issueA),
        .issueB(issueB),
        .issueTag(issueTag)
    );

    aluUnit aluUnit_i (
        .clk(clk),
        .rstN(rstN),
        .issueValid(issueValid),
        .issueOp(issueOp),
        .issueA(issueA),
        .issueB(issueB),
        .issueTag(issueTag),
        .cdb(cdb)
    );

endmodule

// ==== logic/oooPkg.sv ====
package oooPkg;

    localparam int xlen = 32;

    // tag width caps the ROB at 16 entries
    localparam int robTagWidth = 4;

    typedef logic [4:0] regAddr_t;
    typedef logic [robTagWidth-1:0] robTag_t;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd
    } aluOp_e;

    typedef enum logic [6:0] {
        opReg = 7'b0110011,
        opImm = 7'b0010011
    } opcode_e;

    typedef struct packed {
        aluOp_e op;
        regAddr_t rs1;
        regAddr_t rs2;
        regAddr_t rd;
        logic writesReg;
        logic useImm;
        logic [xlen-1:0] imm;
    } decodedInst_t;

    // one source operand as seen by the rename table
    typedef struct packed {
        logic busy;
        robTag_t tag;
        logic [xlen-1:0] value;
    } operandRead_t;

    typedef struct packed {
        logic valid;
        robTag_t tag;
        logic [xlen-1:0] value;
    } cdbResult_t;

    typedef struct packed {
        logic valid;
        regAddr_t rd;
        logic [xlen-1:0] value;
        logic writesReg;
    } commit_t;

endpackage

// ==== logic/renameTable.sv ====
`timescale 1ns/1ns

module renameTable (
    input  logic clk,
    input  logic rstN,
    input  logic accept,
    input  oooPkg::decodedInst_t decoded,
    input  oooPkg::robTag_t allocTag,
    input  oooPkg::commit_t commit,
    output oooPkg::operandRead_t src1,
    output oooPkg::operandRead_t src2
);
    import oooPkg::*;

    localparam int pendWidth = robTagWidth + 1;

    logic [xlen-1:0] regValue [32];
    robTag_t regTag [32];
    // in-flight writers per register, busy while nonzero
    logic [pendWidth-1:0] pendCount [32];
    logic renameWrite;
    logic commitWrite;

    assign renameWrite = accept && decoded.writesReg && (decoded.rd != '0);
    assign commitWrite = commit.valid && commit.writesReg && (commit.rd != '0);

    // the latest writer committing now hands its value straight to the read
    function automatic operandRead_t readReg(regAddr_t rs);
        operandRead_t res;
        res = '{busy: 1'b0, tag: '0, value: '0};
        if (rs == '0) begin
            res.value = '0;
        end else if (pendCount[rs] == '0) begin
            res.value = regValue[rs];
        end else if (commitWrite && commit.rd == rs && pendCount[rs] == pendWidth'(1)) begin
            res.value = commit.value;
        end else begin
            res.busy = 1'b1;
            res.tag = regTag[rs];
        end
        return res;
    endfunction

    assign src1 = readReg(decoded.rs1);
    assign src2 = readReg(decoded.rs2);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regValue[i] <= '0;
                pendCount[i] <= '0;
            end
        end else begin
            if (commitWrite) begin
                regValue[commit.rd] <= commit.value;
            end
            for (int i = 1; i < 32; i++) begin
                if (renameWrite && decoded.rd == i && !(commitWrite && commit.rd == i)) begin
                    pendCount[i] <= pendCount[i] + 1'b1;
                end else if (commitWrite && commit.rd == i && !(renameWrite && decoded.rd == i)) begin
                    pendCount[i] <= pendCount[i] - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (renameWrite) begin
            regTag[decoded.rd] <= allocTag;
        end
    end

endmodule

// ==== logic/reorderBuffer.sv ====
`timescale 1ns/1ns

module reorderBuffer #(
    parameter int robDepth = 8
) (
    input  logic clk,
    input  logic rstN,
    input  logic instValid,
    input  logic stationFull,
    input  oooPkg::decodedInst_t decoded,
    input  oooPkg::cdbResult_t cdb,
    input  oooPkg::robTag_t lookupTag1,
    input  oooPkg::robTag_t lookupTag2,
    output logic lookupReady1,
    output logic [oooPkg::xlen-1:0] lookupValue1,
    output logic lookupReady2,
    output logic [oooPkg::xlen-1:0] lookupValue2,
    output logic stall,
    output logic accept,
    output oooPkg::robTag_t allocTag,
    output oooPkg::commit_t commit
);
    import oooPkg::*;

    localparam int idxWidth = (robDepth > 1) ? $clog2(robDepth) : 1;
    localparam int countWidth = robTagWidth + 1;

    robTag_t head;
    robTag_t tail;
    logic [countWidth-1:0] count;
    logic [robDepth-1:0] entryReady;
    logic [robDepth-1:0] entryWrites;
    regAddr_t entryRd [robDepth];
    logic [xlen-1:0] entryValue [robDepth];

    logic robFull;
    logic doCommit;
    logic busHit1;
    logic busHit2;
    logic [idxWidth-1:0] headIdx;
    logic [idxWidth-1:0] tailIdx;
    logic [idxWidth-1:0] cdbIdx;
    logic [idxWidth-1:0] lookupIdx1;
    logic [idxWidth-1:0] lookupIdx2;

    // wrap at robDepth, so depths below 16 use only the low tags
    function automatic robTag_t nextPtr(robTag_t ptr);
        return (ptr == robTag_t'(robDepth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign headIdx = head[idxWidth-1:0];
    assign tailIdx = tail[idxWidth-1:0];
    assign cdbIdx = cdb.tag[idxWidth-1:0];
    assign lookupIdx1 = lookupTag1[idxWidth-1:0];
    assign lookupIdx2 = lookupTag2[idxWidth-1:0];

    assign robFull = (count == countWidth'(robDepth));
    assign stall = robFull || stationFull;
    assign accept = instValid && !stall;
    assign allocTag = tail;

    // a result on the bus this cycle counts as ready
    assign busHit1 = cdb.valid && (cdb.tag == lookupTag1);
    assign busHit2 = cdb.valid && (cdb.tag == lookupTag2);
    assign lookupReady1 = entryReady[lookupIdx1] || busHit1;
    assign lookupValue1 = busHit1 ? cdb.value : entryValue[lookupIdx1];
    assign lookupReady2 = entryReady[lookupIdx2] || busHit2;
    assign lookupValue2 = busHit2 ? cdb.value : entryValue[lookupIdx2];

    assign doCommit = (count != '0) && entryReady[headIdx];
    assign commit = '{
        valid: doCommit,
        rd: entryRd[headIdx],
        value: entryValue[headIdx],
        writesReg: entryWrites[headIdx]
    };

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            entryReady <= '0;
        end else begin
            if (accept) begin
                tail <= nextPtr(tail);
                entryReady[tailIdx] <= 1'b0;
            end
            if (cdb.valid) begin
                entryReady[cdbIdx] <= 1'b1;
            end
            if (doCommit) begin
                head <= nextPtr(head);
            end
            if (accept && !doCommit) begin
                count <= count + 1'b1;
            end else if (!accept && doCommit) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            entryRd[tailIdx] <= decoded.rd;
            entryWrites[tailIdx] <= decoded.writesReg;
        end
        if (cdb.valid) begin
            entryValue[cdbIdx] <= cdb.value;
        end
    end

endmodule

// ==== testbench/oooCoreTb.sv ====
`timescale 1ns/1ns

module oooCoreTb;
    import oooPkg::*;

    localparam int maxInsts = 64;
    localparam int waitLimit = 200;
    // line range of the gap-free dependent burst in the data file
    localparam int burstFirst = 29;
    localparam int burstLast = 38;
    // the two writes to x26 go back to back
    localparam int rewriteFirst = 26;

    logic clk;
    logic rstN;
    logic instValid;
    logic [31:0] inst;
    logic stall;
    commit_t commit;

    // three words per line: encoding, rd, value
    logic [31:0] testMem [3*maxInsts];
    int numInsts;
    int acceptCount;
    int commitCount;
    logic sawStall;
    logic [31:0] lcgState;

    oooCore #(
        .robDepth(8),
        .stationDepth(4)
    ) dut_i (
        .clk(clk),
        .rstN(rstN),
        .instValid(instValid),
        .inst(inst),
        .stall(stall),
        .commit(commit)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    function automatic logic [31:0] nextRandom(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1);
    endtask

    // called on a rising edge, returns on the edge that takes the instruction
    task automatic sendInst(input logic [31:0] word);
        int waited;
        waited = 0;
        instValid <= 1'b1;
        inst <= word;
        @(negedge clk);
        while (stall && waited < waitLimit) begin
            sawStall = 1'b1;
            waited++;
            @(negedge clk);
        end
        if (stall) begin
            abortRun("stall stayed high and the instruction was never accepted");
        end else begin
            @(posedge clk);
            acceptCount++;
        end
    endtask

    // commit monitor, samples mid-cycle
    initial begin
        logic [31:0] expRd;
        logic [31:0] expValue;
        forever begin
            @(negedge clk);
            if (rstN && commit.valid) begin
                assert (commitCount < acceptCount)
                    else abortRun("commit seen without a matching accepted instruction");
                expRd = testMem[3*commitCount + 1];
                expValue = testMem[3*commitCount + 2];
                assert (commit.rd == expRd[4:0])
                    else abortRun($sformatf("error commit.rd expected %h got %h",
                                            expRd[4:0], commit.rd));
                assert (commit.writesReg == (expRd[4:0] != '0))
                    else abortRun($sformatf("error commit.writesReg expected %h got %h",
                                            (expRd[4:0] != '0), commit.writesReg));
                assert (commit.value == expValue)
                    else abortRun($sformatf("error commit.value expected %08h got %08h",
                                            expValue, commit.value));
                commitCount++;
            end
        end
    end

    initial begin
        int gap;
        int waited;
        instValid = 1'b0;
        inst = '0;
        rstN = 1'b0;
        acceptCount = 0;
        commitCount = 0;
        numInsts = 0;
        sawStall = 1'b0;
        lcgState = 32'h5629c621;
        for (int i = 0; i < 3*maxInsts; i++) begin
            testMem[i] = {16'hbad0, 16'(i)};
        end
        $readmemh("testbench/testdata.txt", testMem);
        // an all-zero encoding ends the list
        while (numInsts < maxInsts && testMem[3*numInsts] != '0) begin
            numInsts++;
        end
        assert (numInsts > burstLast)
            else abortRun("data file holds fewer instructions than expected");

        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        repeat (2) @(negedge clk);
        assert (!stall)
            else abortRun($sformatf("error stall expected 0 got %h", stall));
        assert (!commit.valid)
            else abortRun($sformatf("error commit.valid expected 0 got %h", commit.valid));

        @(posedge clk);
        for (int i = 0; i < numInsts; i++) begin
            if (i == burstFirst) begin
                sawStall = 1'b0;
            end
            sendInst(testMem[3*i]);
            if ((i < burstFirst || i >= burstLast) && i != rewriteFirst) begin
                lcgState = nextRandom(lcgState);
                gap = int'(lcgState[17:16]);
                if (gap > 0) begin
                    instValid <= 1'b0;
                    repeat (gap) @(posedge clk);
                end
            end
            if (i == burstLast) begin
                assert (sawStall)
                    else abortRun("stall never rose during the long dependent burst");
            end
        end
        instValid <= 1'b0;

        waited = 0;
        while (commitCount < numInsts && waited < waitLimit) begin
            @(negedge clk);
            waited++;
        end
        if (commitCount < numInsts) begin
            abortRun("timed out waiting for the remaining commits");
        end else begin
            // idle cycles let the monitor catch any extra commit
            repeat (10) @(negedge clk);
            @(posedge clk);
            $display("All checks passed");
            $finish;
        end
    end

endmodule

// ==== testbench/oooCore_properties.sv ====
`timescale 1ns/1ns

module oooCore_properties (
    input  logic clk,
    input  logic rstN,
    input  logic stall,
    input  oooPkg::commit_t commit,
    input  oooPkg::cdbResult_t cdb
);
    import oooPkg::*;

    stallKnown: assert property (@(posedge clk) disable iff (!rstN) !$isunknown(stall))
        else $error("stall is unknown while out of reset");

    // nothing can be in flight right after reset
    noEarlyCommit: assert property (@(posedge clk) $rose(rstN) |-> !commit.valid)
        else $error("commit valid in the first cycle after reset release");

    noRepeatedTag: assert property (@(posedge clk) disable iff (!rstN)
        (cdb.valid && $past(cdb.valid)) |-> (cdb.tag != $past(cdb.tag)))
        else $error("bus carried the same tag on two consecutive cycles");

endmodule

bind oooCore oooCore_properties properties_i (
    .clk(clk),
    .rstN(rstN),
    .stall(stall),
    .commit(commit),
    .cdb(cdb)
);

// ==== testbench/testdata.txt ====
// columns: instruction encoding, expected rd, expected commit value (all hex)
// a line of zeros ends the list
// independent ops, immediate then register forms
06400093 01 00000064 // addi x1, x0, 100
FF900113 02 FFFFFFF9 // addi x2, x0, -7
5A504193 03 000005A5 // xori x3, x0, 0x5a5
0F006213 04 000000F0 // ori x4, x0, 0xf0
0FF17293 05 000000F9 // andi x5, x2, 0xff
00409313 06 00000640 // slli x6, x1, 4
01C15393 07 0000000F // srli x7, x2, 28
40115413 08 FFFFFFFC // srai x8, x2, 1
00012493 09 00000001 // slti x9, x2, 0
0650B513 0A 00000001 // sltiu x10, x1, 0x65
402085B3 0B 0000006B // sub x11, x1, x2
00309633 0C 00000C80 // sll x12, x1, x3
001126B3 0D 00000001 // slt x13, x2, x1
00113733 0E 00000000 // sltu x14, x2, x1
0041C7B3 0F 00000555 // xor x15, x3, x4
00715833 10 0001FFFF // srl x16, x2, x7
407158B3 11 FFFFFFFF // sra x17, x2, x7
0041E933 12 000005F5 // or x18, x3, x4
0021F9B3 13 000005A1 // and x19, x3, x2
00608A33 14 000006A4 // add x20, x1, x6
// dependent chain
001A0A93 15 000006A5 // addi x21, x20, 1
015A8AB3 15 00000D4A // add x21, x21, x21
401A8B33 16 00000CE6 // sub x22, x21, x1
015B4BB3 17 000001AC // xor x23, x22, x21
// x0 as destination and source
00508013 00 00000069 // addi x0, x1, 5
00100C33 18 00000064 // add x24, x0, x1
// rewrite while the older write is in flight
11100D13 1A 00000111 // addi x26, x0, 0x111
22200D13 1A 00000222 // addi x26, x0, 0x222
001D0D93 1B 00000223 // addi x27, x26, 1
// burst longer than the ROB, sent without gaps
00100E13 1C 00000001 // addi x28, x0, 1
01CE0E33 1C 00000002 // add x28, x28, x28
01CE0E33 1C 00000004
01CE0E33 1C 00000008
01CE0E33 1C 00000010
01CE0E33 1C 00000020
01CE0E33 1C 00000040
01CE0E33 1C 00000080
01CE0E33 1C 00000100
01CE0E33 1C 00000200
// readers after the burst
000D0F33 1E 00000222 // add x30, x26, x0
400E0EB3 1D 00000200 // sub x29, x28, x0
00000000 00 00000000
